// File: include/fb_display_macros.svh
// ====================
// screen, framebuffer and palette sizes for the display pipeline
// include wherever a size is needed
// ====================
`ifndef FB_DISPLAY_MACROS_SVH
`define FB_DISPLAY_MACROS_SVH

// 640x480 raster, active and full frame
`define H_RES        640
`define V_RES        480
`define H_RES_FULL   800
`define V_RES_FULL   525

// sync pulses, active low over [start, end]
`define H_SYNC_START 656
`define H_SYNC_END   751
`define V_SYNC_START 490
`define V_SYNC_END   491

`define FB_WIDTH     320  // framebuffer pixels per line
`define FB_HEIGHT    240  // framebuffer lines
`define LB_SCALE_H   2    // each pixel shown twice
`define LB_SCALE_V   2    // each line shown twice
`define PAL_ENTRIES  64   // clut depth

`define CORDW        10   // screen coordinate bits
`define FB_ADDRW     17   // covers 76800 pixels
`define LB_ADDRW     9    // covers 320 entries

`endif

// File: verilog/fb_display_pkg.sv
// ====================
// types shared by the display pipeline blocks
// ====================
`default_nettype none

`include "fb_display_macros.svh"

package fb_display_pkg;

    typedef logic [`CORDW-1:0]                coord_t;     // screen x or y
    typedef logic [`FB_ADDRW-1:0]             fb_addr_t;   // linear fb address
    typedef logic [$clog2(`PAL_ENTRIES)-1:0]  colr_idx_t;  // palette index
    typedef logic [3:0]                       chan_t;      // one colour channel
    typedef logic [`LB_ADDRW-1:0]             lb_addr_t;   // linebuffer address

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb_t;

    // raster position and sync levels
    typedef struct packed {
        coord_t sx;
        coord_t sy;
        logic   hsync;  // active low
        logic   vsync;  // active low
        logic   de;     // inside visible area
    } scan_t;

    // host framebuffer write strobe
    typedef struct packed {
        logic      we;
        fb_addr_t  addr;
        colr_idx_t idx;
    } fb_wr_t;

    // host palette write strobe
    typedef struct packed {
        logic      we;
        colr_idx_t idx;
        rgb_t      colr;
    } pal_wr_t;

    typedef struct packed {
        logic     we;
        lb_addr_t addr;
    } lb_wr_t;

    typedef enum logic [2:0] {
        IDLE,        // wait for last line of frame
        START,       // rewind framebuffer position
        AWAIT_POS,   // wait for hblank
        START_LINE,  // decide fetch or repeat
        READ_FB,     // copy one fb line
        LINE_DONE    // check for last fb line
    } loader_state_t;

endpackage

`default_nettype wire

// File: verilog/display_timings.sv
// ====================
// 640x480 raster counters with sync and enable decode
// ====================
`default_nettype none
`timescale 1ns/1ns

`include "fb_display_macros.svh"

module display_timings
    import fb_display_pkg::*;
(
    input  wire logic clk_pix,
    input  wire logic rst,
    output scan_t     scan
);

    coord_t sx;  // 0..799
    coord_t sy;  // 0..524

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == coord_t'(`H_RES_FULL - 1)) begin  // end of line
            sx <= '0;
            sy <= (sy == coord_t'(`V_RES_FULL - 1)) ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // syncs are negative polarity at 640x480
    always_comb begin
        scan.sx    = sx;
        scan.sy    = sy;
        scan.hsync = ~(sx >= coord_t'(`H_SYNC_START) && sx <= coord_t'(`H_SYNC_END));
        scan.vsync = ~(sy >= coord_t'(`V_SYNC_START) && sy <= coord_t'(`V_SYNC_END));
        scan.de    = (sx < coord_t'(`H_RES)) && (sy < coord_t'(`V_RES));
    end

endmodule

`default_nettype wire

// File: verilog/lb_loader.sv
// ====================
// copies framebuffer lines into the linebuffer during hblank
// one fetch serves LB_SCALE_V screen lines
// ====================
`default_nettype none
`timescale 1ns/1ns

`include "fb_display_macros.svh"

module lb_loader
    import fb_display_pkg::*;
(
    input  wire logic  clk_pix,
    input  wire logic  rst,
    input  wire scan_t scan,
    output fb_addr_t   fb_addr_read,
    output lb_wr_t     lb_wr
);

    localparam int LINE_W = $clog2(`FB_HEIGHT);
    localparam int RPT_W  = $clog2(`LB_SCALE_V);

    loader_state_t state, state_next;

    logic [LINE_W-1:0] fb_line_cnt;  // framebuffer line in progress
    logic [RPT_W-1:0]  lb_line_rpt;  // screen line within repeat group
    lb_addr_t          lb_addr;      // write address, aligned with fb read

    // write pipe, stage 1; stage 2 is lb_wr itself
    logic     we_p1;
    lb_addr_t addr_p1;

    logic hblank_start;
    logic frame_start;
    logic fb_read_line;
    logic fb_last_pixel;
    logic fb_last_line;

    always_comb begin
        hblank_start  = (scan.sx == coord_t'(`H_RES));
        frame_start   = (scan.sy == coord_t'(`V_RES_FULL - 1));  // line before frame
        fb_read_line  = (lb_line_rpt == '0);  // fetch only on first of group
        fb_last_pixel = (lb_addr == lb_addr_t'(`FB_WIDTH - 1));
        fb_last_line  = (fb_line_cnt == LINE_W'(`FB_HEIGHT - 1));
    end

    always_comb begin
        case (state)
            IDLE:       state_next = frame_start ? START : IDLE;
            START:      state_next = AWAIT_POS;
            AWAIT_POS:  state_next = hblank_start ? START_LINE : AWAIT_POS;
            START_LINE: state_next = fb_read_line ? READ_FB : AWAIT_POS;
            READ_FB:    state_next = fb_last_pixel ? LINE_DONE : READ_FB;
            LINE_DONE:  state_next = fb_last_line ? IDLE : AWAIT_POS;
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // framebuffer position and line counters
    always_ff @(posedge clk_pix) begin
        case (state)
            START: begin
                fb_addr_read <= '0;  // top left of framebuffer
                fb_line_cnt  <= '0;
                lb_line_rpt  <= '0;
            end
            START_LINE: begin
                lb_addr <= '0;
                if (lb_line_rpt == RPT_W'(`LB_SCALE_V - 1)) begin
                    fb_line_cnt <= fb_line_cnt + 1'b1;
                    lb_line_rpt <= '0;
                end else begin
                    lb_line_rpt <= lb_line_rpt + 1'b1;
                end
            end
            READ_FB: begin
                // ends on start of next fb line
                fb_addr_read <= fb_addr_read + 1'b1;
                lb_addr      <= lb_addr + 1'b1;
            end
            default: ;
        endcase
    end

    // two stages cover fb_ram and clut latency
    always_ff @(posedge clk_pix) begin
        we_p1         <= (state == READ_FB);
        addr_p1       <= lb_addr;
        lb_wr.we      <= we_p1;
        lb_wr.addr    <= addr_p1;
        if (rst) begin
            we_p1    <= 1'b0;
            lb_wr.we <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fb_ram.sv
// ====================
// framebuffer of colour indices, host write port and display read port
// ====================
`default_nettype none
`timescale 1ns/1ns

`include "fb_display_macros.svh"

module fb_ram
    import fb_display_pkg::*;
(
    input  wire logic     clk_pix,
    input  wire fb_wr_t   fb_wr,
    input  wire fb_addr_t addr_read,
    output colr_idx_t     idx
);

    localparam int DEPTH = `FB_WIDTH * `FB_HEIGHT;  // 76800

    colr_idx_t mem [DEPTH];

    always_ff @(posedge clk_pix) begin
        if (fb_wr.we) mem[fb_wr.addr] <= fb_wr.idx;  // host strobe
        idx <= mem[addr_read];  // one cycle latency
    end

endmodule

`default_nettype wire

// File: verilog/clut.sv
// ====================
// colour lookup, maps a 6-bit index to 12-bit rgb
// host fills entries with single-cycle strobes
// ====================
`default_nettype none
`timescale 1ns/1ns

`include "fb_display_macros.svh"

module clut
    import fb_display_pkg::*;
(
    input  wire logic      clk_pix,
    input  wire pal_wr_t   pal_wr,
    input  wire colr_idx_t idx,
    output rgb_t           colr
);

    rgb_t palette [`PAL_ENTRIES];

    always_ff @(posedge clk_pix) begin
        if (pal_wr.we) begin
            palette[pal_wr.idx] <= pal_wr.colr;
        end
        colr <= palette[idx];  // registered lookup
    end

endmodule

`default_nettype wire

// File: verilog/linebuffer.sv
// ====================
// one scaled line of rgb, written by the loader and read by the raster
// each entry is read LB_SCALE_H times in a row
// ====================
`default_nettype none
`timescale 1ns/1ns

`include "fb_display_macros.svh"

module linebuffer
    import fb_display_pkg::*;
(
    input  wire logic   clk_pix,
    input  wire lb_wr_t lb_wr,
    input  wire rgb_t   data_in,
    input  wire scan_t  scan,
    output rgb_t        data_out
);

    localparam int RPT_W = $clog2(`LB_SCALE_H);

    // separate store per channel
    chan_t mem_r [`FB_WIDTH];
    chan_t mem_g [`FB_WIDTH];
    chan_t mem_b [`FB_WIDTH];

    lb_addr_t         addr_read;
    logic [RPT_W-1:0] pix_rpt;  // repeats of current entry

    always_ff @(posedge clk_pix) begin
        if (lb_wr.we) begin
            mem_r[lb_wr.addr] <= data_in.r;
            mem_g[lb_wr.addr] <= data_in.g;
            mem_b[lb_wr.addr] <= data_in.b;
        end
    end

    // two cycles early, addr 0 at sx 799 and data at sx 0
    always_ff @(posedge clk_pix) begin
        if (scan.sx == coord_t'(`H_RES_FULL - 2)) begin
            addr_read <= '0;
            pix_rpt   <= '0;
        end else if (addr_read < lb_addr_t'(`FB_WIDTH - 1)) begin  // hold on last entry
            if (pix_rpt == RPT_W'(`LB_SCALE_H - 1)) begin
                pix_rpt   <= '0;
                addr_read <= addr_read + 1'b1;
            end else begin
                pix_rpt <= pix_rpt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        data_out.r <= mem_r[addr_read];
        data_out.g <= mem_g[addr_read];
        data_out.b <= mem_b[addr_read];
    end

endmodule

`default_nettype wire

// File: verilog/fb_display_top.sv
// ====================
// scaled framebuffer display, 320x240 indices shown at 640x480
// host fills palette and framebuffer through write strobes
// ====================
`default_nettype none
`timescale 1ns/1ns

module fb_display_top
    import fb_display_pkg::*;
(
    input  wire logic    clk_pix,
    input  wire logic    rst,
    input  wire fb_wr_t  fb_wr,
    input  wire pal_wr_t pal_wr,
    output logic         vga_hsync,
    output logic         vga_vsync,
    output chan_t        vga_r,
    output chan_t        vga_g,
    output chan_t        vga_b
);

    scan_t     scan;
    fb_addr_t  fb_addr_read;
    lb_wr_t    lb_wr;
    colr_idx_t colr_idx;   // from framebuffer
    rgb_t      clut_colr;  // into linebuffer
    rgb_t      lb_colr;    // out of linebuffer

    display_timings i_timings (
        .clk_pix,
        .rst,
        .scan
    );

    lb_loader i_loader (
        .clk_pix,
        .rst,
        .scan,
        .fb_addr_read,
        .lb_wr
    );

    fb_ram i_fb_ram (
        .clk_pix,
        .fb_wr,
        .addr_read (fb_addr_read),
        .idx       (colr_idx)
    );

    clut i_clut (
        .clk_pix,
        .pal_wr,
        .idx  (colr_idx),
        .colr (clut_colr)
    );

    linebuffer i_linebuffer (
        .clk_pix,
        .lb_wr,
        .data_in  (clut_colr),
        .scan,
        .data_out (lb_colr)
    );

    // black in blanking
    always_comb begin
        vga_hsync = scan.hsync;
        vga_vsync = scan.vsync;
        vga_r     = scan.de ? lb_colr.r : '0;
        vga_g     = scan.de ? lb_colr.g : '0;
        vga_b     = scan.de ? lb_colr.b : '0;
    end

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
// ====================
// pixel clock at 20 ns and reset held for two edges
// ====================
`default_nettype none
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_pix,
    output logic rst
);

    initial begin
        clk_pix = 1'b0;
        forever #10 clk_pix = ~clk_pix;  // 50 MHz stand-in for 25.175
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk_pix);
        rst <= 1'b0;  // released on second edge
    end

endmodule

`default_nettype wire

// File: test/tb_fb_display.sv
// ====================
// testbench for the scaled display
// fills palette and framebuffer in frame 0 then checks syncs,
// blanking and pixel colours in frames 1 and 2
// ====================
`default_nettype none
`timescale 1ns/1ns

`include "fb_display_macros.svh"

module tb_fb_display
    import fb_display_pkg::*;
();

    localparam int FRAME_CYCLES = `H_RES_FULL * `V_RES_FULL;
    localparam int MAX_PROBES   = 64;
    localparam int N_RAND       = 24;   // one per band of 10 line pairs
    localparam int N_PAL        = 16;   // entries used by the fill

    logic    clk_pix;
    logic    rst;
    fb_wr_t  fb_wr;
    pal_wr_t pal_wr;
    logic    vga_hsync;
    logic    vga_vsync;
    chan_t   vga_r;
    chan_t   vga_g;
    chan_t   vga_b;
    rgb_t    dut_rgb;

    coord_t raster_x;   // own copy of the scan position
    coord_t raster_y;
    int     frame_cnt;

    rgb_t shadow_pal [N_PAL];
    int   probe_sx   [MAX_PROBES];
    int   probe_sy   [MAX_PROBES];
    rgb_t probe_rgb  [MAX_PROBES];
    int   n_pal;
    int   n_probes;
    int   probe_ptr;     // next file probe in raster order

    logic [31:0] lfsr_state;

    assign dut_rgb = {vga_r, vga_g, vga_b};

    tb_clk_gen i_clk_gen (
        .clk_pix,
        .rst
    );

    fb_display_top i_dut (
        .clk_pix,
        .rst,
        .fb_wr,
        .pal_wr,
        .vga_hsync,
        .vga_vsync,
        .vga_r,
        .vga_g,
        .vga_b
    );

    // 800x525 raster count from reset release
    always @(posedge clk_pix) begin
        if (rst) begin
            raster_x  <= '0;
            raster_y  <= '0;
            frame_cnt <= 0;
        end else if (raster_x == coord_t'(`H_RES_FULL - 1)) begin
            raster_x <= '0;
            if (raster_y == coord_t'(`V_RES_FULL - 1)) begin
                raster_y  <= '0;
                frame_cnt <= frame_cnt + 1;
            end else begin
                raster_y <= raster_y + 1'b1;
            end
        end else begin
            raster_x <= raster_x + 1'b1;
        end
    end

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_rgb(input rgb_t got, input rgb_t expected, input string what);
        if (got !== expected) begin
            $display("[FAIL] t=%0t %s at sx=%0d sy=%0d, got %h expected %h",
                     $time, what, raster_x, raster_y, got, expected);
            abort_run();
        end
    endtask

    task automatic check_sync(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("[FAIL] t=%0t %s at sx=%0d sy=%0d, got %b expected %b",
                     $time, what, raster_x, raster_y, got, expected);
            abort_run();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int unsigned take_random_bits(input int nbits);
        int unsigned val;
        int          b;
        val = 0;
        for (b = 0; b < nbits; b++) begin
            lfsr_state = lfsr_step(lfsr_state);  // one step per bit
            val        = (val << 1) | lfsr_state[0];
        end
        return val;
    endfunction

    task automatic wait_for_frame(input int n);
        int cycles;
        cycles = 0;
        while (!(frame_cnt == n && raster_x == '0 && raster_y == '0)) begin
            @(negedge clk_pix);
            cycles++;
            if (cycles > FRAME_CYCLES + 16) begin
                $display("timeout: frame %0d did not arrive", n);
                abort_run();
            end
        end
    endtask

    task automatic wait_for_pos(input int x, input int y);
        int cycles;
        cycles = 0;
        while (!(raster_x == coord_t'(x) && raster_y == coord_t'(y))) begin
            @(negedge clk_pix);
            cycles++;
            if (cycles > FRAME_CYCLES) begin
                $display("timeout: raster position %0d,%0d was not reached", x, y);
                abort_run();
            end
        end
    endtask

    // palette lines first and probes after them
    // comment lines do not scan and are skipped
    task automatic read_testdata();
        int               fd;
        int               n_lines;
        int               a;
        int               b;
        int               c;
        logic [8*128-1:0] line_buf;
        fd      = $fopen("test/fb_display_testdata.txt", "r");
        n_lines = 0;
        if (fd == 0) begin
            $display("could not open the test data file");
            abort_run();
        end
        while (!$feof(fd) && n_lines < 1000) begin
            line_buf = '0;
            n_lines++;
            if ($fgets(line_buf, fd) > 0) begin
                if (n_pal < N_PAL) begin
                    if ($sscanf(line_buf, "%h %h", a, b) == 2 && a < N_PAL) begin
                        shadow_pal[a] = rgb_t'(b[11:0]);
                        n_pal++;
                    end
                end else if (n_probes < MAX_PROBES) begin
                    if ($sscanf(line_buf, "%d %d %h", a, b, c) == 3) begin
                        probe_sx[n_probes]  = a;
                        probe_sy[n_probes]  = b;
                        probe_rgb[n_probes] = rgb_t'(c[11:0]);
                        n_probes++;
                    end
                end
            end
        end
        $fclose(fd);
        if (n_pal != N_PAL || n_probes == 0) begin
            $display("test data file holds %0d palette lines and %0d probes", n_pal, n_probes);
            abort_run();
        end
    endtask

    task automatic load_palette();
        int p;
        for (p = 0; p < N_PAL; p++) begin
            @(posedge clk_pix);
            pal_wr.we   <= 1'b1;
            pal_wr.idx  <= colr_idx_t'(p);
            pal_wr.colr <= shadow_pal[p];
        end
        @(posedge clk_pix);
        pal_wr.we <= 1'b0;
    endtask

    // index (fb_x + fb_y) mod 16 everywhere
    task automatic load_framebuffer();
        int x;
        int y;
        for (y = 0; y < `FB_HEIGHT; y++) begin
            for (x = 0; x < `FB_WIDTH; x++) begin
                @(posedge clk_pix);
                fb_wr.we   <= 1'b1;
                fb_wr.addr <= fb_addr_t'(y * `FB_WIDTH + x);
                fb_wr.idx  <= colr_idx_t'((x + y) % N_PAL);
            end
        end
        @(posedge clk_pix);
        fb_wr.we <= 1'b0;
    endtask

    // syncs and blanking over the whole of frame 1 with file probes on the way
    task automatic scan_frame_one();
        int   n;
        logic exp_h;
        logic exp_v;
        logic active;
        for (n = 0; n < FRAME_CYCLES; n++) begin
            exp_h  = !(raster_x >= `H_SYNC_START && raster_x <= `H_SYNC_END);
            exp_v  = !(raster_y >= `V_SYNC_START && raster_y <= `V_SYNC_END);
            active = (raster_x < `H_RES) && (raster_y < `V_RES);
            check_sync(vga_hsync, exp_h, "hsync level");
            check_sync(vga_vsync, exp_v, "vsync level");
            if (!active) begin
                check_rgb(dut_rgb, rgb_t'(0), "colour in blanking");
            end else if (probe_ptr < n_probes && raster_x == probe_sx[probe_ptr]
                         && raster_y == probe_sy[probe_ptr]) begin
                check_rgb(dut_rgb, probe_rgb[probe_ptr], "file probe");
                probe_ptr++;
            end
            @(negedge clk_pix);
        end
    endtask

    // random 2x2 blocks in frame 2 with one per band to keep raster order
    task automatic check_random_blocks();
        int   k;
        int   fx;
        int   fy;
        rgb_t base;
        for (k = 0; k < N_RAND; k++) begin
            fy = k * 10 + int'(take_random_bits(16) % 10);
            fx = int'(take_random_bits(16) % `FB_WIDTH);
            wait_for_pos(2 * fx, 2 * fy);
            check_rgb(dut_rgb, shadow_pal[(fx + fy) % N_PAL], "random probe");
            base = dut_rgb;
            @(negedge clk_pix);
            check_rgb(dut_rgb, base, "odd pixel of pair");
            wait_for_pos(2 * fx, 2 * fy + 1);
            check_rgb(dut_rgb, base, "odd line of pair");
            @(negedge clk_pix);
            check_rgb(dut_rgb, base, "odd pixel on odd line");
        end
    endtask

    initial begin
        fb_wr        = '0;
        pal_wr       = '0;
        n_pal        = 0;
        n_probes     = 0;
        probe_ptr    = 0;
        lfsr_state   = 32'heeba_d5eb;
        read_testdata();

        @(negedge clk_pix);  // first edge seen while still in reset
        check_sync(vga_hsync, 1'b1, "hsync in reset");
        check_sync(vga_vsync, 1'b1, "vsync in reset");
        while (rst) begin
            @(negedge clk_pix);
            if ($time > 200) begin
                $display("timeout: reset was never released");
                abort_run();
            end
        end

        load_palette();
        load_framebuffer();
        @(negedge clk_pix);
        if (frame_cnt != 0) begin
            $display("palette and framebuffer writes ran past frame 0");
            abort_run();
        end

        wait_for_frame(1);
        scan_frame_one();
        if (probe_ptr != n_probes) begin
            $display("file probe %0d was never reached, probes must be in raster order",
                     probe_ptr);
            abort_run();
        end
        wait_for_frame(2);
        check_random_blocks();

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
verilog/fb_display_pkg.sv
verilog/display_timings.sv
verilog/lb_loader.sv
verilog/fb_ram.sv
verilog/clut.sv
verilog/linebuffer.sv
verilog/fb_display_top.sv
test/tb_clk_gen.sv
test/tb_fb_display.sv

// File: test/fb_display_testdata.txt
# palette lines: index colour, both hex, 16 of them
# probe lines: sx sy (decimal) expected rgb (hex), in raster order
0 123
1 f00
2 0f0
3 00f
4 ff0
5 0ff
6 f0f
7 fff
8 888
9 800
a 080
b 008
c 880
d 088
e 808
f 444
# probes, colour is palette[(sx/2 + sy/2) mod 16]
0 0 123
2 0 f00
638 0 444
1 1 123
6 4 0ff
13 7 800
100 50 008
101 51 008
77 88 0f0
511 199 0f0
320 240 888
250 301 00f
444 333 ff0
614 460 800
0 478 444
639 479 808
